/* boru_if.sv */
// Stage registers carry a valid bit only because no stage ever refuses an instruction.
`timescale 1ns/1ps

// Decode to execute.
interface cyo_yrt_if;

    import cekirdek_pkg::*;

    logic            gecerli;
    mikroislem_t     mikroislem;
    logic [XLEN-1:0] deger1;
    logic [XLEN-1:0] deger2;
    logic [4:0]      rd_adres;
    logic            yaz_yazmac;
    logic [XLEN-1:0] ps;
    logic            gecersiz;

    modport kaynak (output gecerli, mikroislem, deger1, deger2, rd_adres, yaz_yazmac, ps,
                    gecersiz);
    modport hedef  (input  gecerli, mikroislem, deger1, deger2, rd_adres, yaz_yazmac, ps,
                    gecersiz);

endinterface

// Execute output register to writeback.
interface yrt_gy_if;

    import cekirdek_pkg::*;

    logic            gecerli;
    logic [4:0]      rd_adres;
    logic [XLEN-1:0] rd_deger;
    logic            yaz_yazmac;
    logic [XLEN-1:0] ps;
    logic            gecersiz;

    modport kaynak (output gecerli, rd_adres, rd_deger, yaz_yazmac, ps, gecersiz);
    modport hedef  (input  gecerli, rd_adres, rd_deger, yaz_yazmac, ps, gecersiz);

endinterface

/* cekirdek.sv */
// Four-stage core with ALU and LUI only; any other word retires as invalid with no write.
`timescale 1ns/1ps

module cekirdek (
    input  logic                          clk_i,
    input  logic                          rst_i,

    input  logic                          l1b_bekle_i,
    input  logic [cekirdek_pkg::XLEN-1:0] l1b_deger_i,
    output logic                          l1b_chip_select_n_o,
    output logic [cekirdek_pkg::XLEN-1:0] l1b_adres_o,

    output logic                          gy_gecerli_o,
    output logic [cekirdek_pkg::XLEN-1:0] gy_ps_o,
    output logic                          gy_yaz_yazmac_o,
    output logic [4:0]                    gy_rd_adres_o,
    output logic [cekirdek_pkg::XLEN-1:0] gy_rd_deger_o,
    output logic                          gy_gecersiz_o
);

    import cekirdek_pkg::*;

    logic            gtr_gecerli_w;
    logic [XLEN-1:0] gtr_buyruk_w;
    logic [XLEN-1:0] gtr_ps_w;
    logic [XLEN-1:0] yrt_yonlendir_deger_w;
    logic [4:0]      ddb_rs1_adres_w;
    logic [4:0]      ddb_rs2_adres_w;
    yonlendir_t      ddb_yonlendir_kontrol1_w;
    yonlendir_t      ddb_yonlendir_kontrol2_w;

    cyo_yrt_if cyo_yrt ();
    yrt_gy_if  yrt_gy ();

    getir getir_dut (
        .clk_i               (clk_i              ),
        .rst_i               (rst_i              ),
        .l1b_bekle_i         (l1b_bekle_i        ),
        .l1b_deger_i         (l1b_deger_i        ),
        .l1b_chip_select_n_o (l1b_chip_select_n_o),
        .l1b_adres_o         (l1b_adres_o        ),
        .cyo_gecerli_o       (gtr_gecerli_w      ),
        .cyo_buyruk_o        (gtr_buyruk_w       ),
        .cyo_ps_o            (gtr_ps_w           )
    );

    coz_yazmacoku coz_yazmacoku_dut (
        .clk_i                    (clk_i                   ),
        .rst_i                    (rst_i                   ),
        .gtr_gecerli_i            (gtr_gecerli_w           ),
        .gtr_buyruk_i             (gtr_buyruk_w            ),
        .gtr_ps_i                 (gtr_ps_w                ),
        .yrt                      (cyo_yrt                 ),
        .yrt_yonlendir_deger_i    (yrt_yonlendir_deger_w   ),
        .gy_yonlendir_deger_i     (yrt_gy.rd_deger         ),
        .gy_yaz_adres_i           (gy_rd_adres_o           ),
        .gy_yaz_deger_i           (gy_rd_deger_o           ),
        .gy_yaz_yazmac_i          (gy_yaz_yazmac_o         ),
        .ddb_yonlendir_kontrol1_i (ddb_yonlendir_kontrol1_w),
        .ddb_yonlendir_kontrol2_i (ddb_yonlendir_kontrol2_w),
        .ddb_rs1_adres_o          (ddb_rs1_adres_w         ),
        .ddb_rs2_adres_o          (ddb_rs2_adres_w         )
    );

    yurut yurut_dut (
        .clk_i                 (clk_i                ),
        .rst_i                 (rst_i                ),
        .cyo                   (cyo_yrt              ),
        .gy                    (yrt_gy               ),
        .cyo_yonlendir_deger_o (yrt_yonlendir_deger_w)
    );

    // The register-file write doubles as the retire trace.
    geri_yaz geri_yaz_dut (
        .clk_i            (clk_i          ),
        .rst_i            (rst_i          ),
        .yrt              (yrt_gy         ),
        .cyo_yaz_adres_o  (gy_rd_adres_o  ),
        .cyo_yaz_deger_o  (gy_rd_deger_o  ),
        .cyo_yaz_yazmac_o (gy_yaz_yazmac_o),
        .gecerli_o        (gy_gecerli_o   ),
        .ps_o             (gy_ps_o        ),
        .gecersiz_o       (gy_gecersiz_o  )
    );

    denetim_durum_birimi denetim_durum_birimi_dut (
        .cyo_rs1_adres_i          (ddb_rs1_adres_w         ),
        .cyo_rs2_adres_i          (ddb_rs2_adres_w         ),
        .yrt                      (cyo_yrt                 ),
        .gy                       (yrt_gy                  ),
        .cyo_yonlendir_kontrol1_o (ddb_yonlendir_kontrol1_w),
        .cyo_yonlendir_kontrol2_o (ddb_yonlendir_kontrol2_w)
    );

endmodule

/* cekirdek_pkg.sv */
// Only OP, OP-IMM and LUI are known to the core and every other encoding decodes as GECERSIZ.
package cekirdek_pkg;

    localparam int XLEN = 32;

    // ============================================================
    // Opcodes and function fields.
    // ============================================================
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LUI    = 7'b0110111;

    localparam logic [2:0] F3_TOPLA = 3'b000;
    localparam logic [2:0] F3_SLL   = 3'b001;
    localparam logic [2:0] F3_SLT   = 3'b010;
    localparam logic [2:0] F3_SLTU  = 3'b011;
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_SAGA  = 3'b101;
    localparam logic [2:0] F3_VEYA  = 3'b110;
    localparam logic [2:0] F3_VE    = 3'b111;

    // SUB and SRA set bit 30.
    localparam logic [6:0] F7_TEMEL = 7'b0000000;
    localparam logic [6:0] F7_ALT   = 7'b0100000;

    // ============================================================
    // Micro-operations and forwarding selects.
    // ============================================================
    typedef enum logic [3:0] {
        TOPLA,
        CIKAR,
        VE,
        VEYA,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI_OP,
        GECERSIZ
    } mikroislem_t;

    typedef enum logic [1:0] {
        YAZMAC,
        YRT,
        GY
    } yonlendir_t;

endpackage

/* coz_yazmacoku.sv */
// Decodes only OP, OP-IMM and LUI, and relies on writeback to never write x0.
`timescale 1ns/1ps

module coz_yazmacoku (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          gtr_gecerli_i,
    input  logic [cekirdek_pkg::XLEN-1:0] gtr_buyruk_i,
    input  logic [cekirdek_pkg::XLEN-1:0] gtr_ps_i,
    cyo_yrt_if.kaynak                     yrt,
    input  logic [cekirdek_pkg::XLEN-1:0] yrt_yonlendir_deger_i,
    input  logic [cekirdek_pkg::XLEN-1:0] gy_yonlendir_deger_i,
    input  logic [4:0]                    gy_yaz_adres_i,
    input  logic [cekirdek_pkg::XLEN-1:0] gy_yaz_deger_i,
    input  logic                          gy_yaz_yazmac_i,
    input  cekirdek_pkg::yonlendir_t      ddb_yonlendir_kontrol1_i,
    input  cekirdek_pkg::yonlendir_t      ddb_yonlendir_kontrol2_i,
    output logic [4:0]                    ddb_rs1_adres_o,
    output logic [4:0]                    ddb_rs2_adres_o
);

    import cekirdek_pkg::*;

    logic [XLEN-1:0] yazmac_r [1:31];

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] anlik;
    logic            anlik_kullan;
    mikroislem_t     mikroislem;
    logic [XLEN-1:0] kaynak1;
    logic [XLEN-1:0] kaynak2;

    assign opcode          = gtr_buyruk_i[6:0];
    assign funct3          = gtr_buyruk_i[14:12];
    assign funct7          = gtr_buyruk_i[31:25];
    assign ddb_rs1_adres_o = gtr_buyruk_i[19:15];
    assign ddb_rs2_adres_o = gtr_buyruk_i[24:20];

    // U immediate for LUI, sign-extended I immediate otherwise.
    assign anlik = (opcode == LUI) ? {gtr_buyruk_i[31:12], 12'b0}
                                   : {{20{gtr_buyruk_i[31]}}, gtr_buyruk_i[31:20]};

    // ============================================================
    // Decode.
    // ============================================================
    always_comb begin
        mikroislem   = GECERSIZ;
        anlik_kullan = 1'b1;
        case (opcode)
            OP: begin
                anlik_kullan = 1'b0;
                if (funct7 == F7_TEMEL) begin
                    case (funct3)
                        F3_TOPLA: mikroislem = TOPLA;
                        F3_SLL:   mikroislem = SLL;
                        F3_SLT:   mikroislem = SLT;
                        F3_SLTU:  mikroislem = SLTU;
                        F3_XOR:   mikroislem = XOR;
                        F3_SAGA:  mikroislem = SRL;
                        F3_VEYA:  mikroislem = VEYA;
                        default:  mikroislem = VE;
                    endcase
                end else if (funct7 == F7_ALT && funct3 == F3_TOPLA) begin
                    mikroislem = CIKAR;
                end else if (funct7 == F7_ALT && funct3 == F3_SAGA) begin
                    mikroislem = SRA;
                end
            end
            OP_IMM: begin
                case (funct3)
                    F3_TOPLA: mikroislem = TOPLA;
                    F3_SLT:   mikroislem = SLT;
                    F3_SLTU:  mikroislem = SLTU;
                    F3_XOR:   mikroislem = XOR;
                    F3_VEYA:  mikroislem = VEYA;
                    F3_VE:    mikroislem = VE;
                    F3_SLL:   mikroislem = (funct7 == F7_TEMEL) ? SLL : GECERSIZ;
                    default: begin
                        if (funct7 == F7_TEMEL) begin
                            mikroislem = SRL;
                        end else if (funct7 == F7_ALT) begin
                            mikroislem = SRA;
                        end
                    end
                endcase
            end
            LUI:     mikroislem = LUI_OP;
            default: mikroislem = GECERSIZ;
        endcase
    end

    // ============================================================
    // Register file and operand select.
    // ============================================================
    always_ff @(posedge clk_i) begin
        if (gy_yaz_yazmac_i && gy_yaz_adres_i != 5'd0) begin
            yazmac_r[gy_yaz_adres_i] <= gy_yaz_deger_i;
        end
    end

    // Write-through covers the instruction three ahead.
    function automatic logic [XLEN-1:0] oku(input logic [4:0] adres);
        if (adres == 5'd0) begin
            return '0;
        end
        if (gy_yaz_yazmac_i && adres == gy_yaz_adres_i) begin
            return gy_yaz_deger_i;
        end
        return yazmac_r[adres];
    endfunction

    always_comb begin
        case (ddb_yonlendir_kontrol1_i)
            YRT:     kaynak1 = yrt_yonlendir_deger_i;
            GY:      kaynak1 = gy_yonlendir_deger_i;
            default: kaynak1 = oku(ddb_rs1_adres_o);
        endcase
        case (ddb_yonlendir_kontrol2_i)
            YRT:     kaynak2 = yrt_yonlendir_deger_i;
            GY:      kaynak2 = gy_yonlendir_deger_i;
            default: kaynak2 = oku(ddb_rs2_adres_o);
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            yrt.gecerli <= 1'b0;
        end else begin
            yrt.gecerli <= gtr_gecerli_i;
        end
    end

    always_ff @(posedge clk_i) begin
        yrt.mikroislem <= mikroislem;
        yrt.deger1     <= kaynak1;
        yrt.deger2     <= anlik_kullan ? anlik : kaynak2;
        yrt.rd_adres   <= gtr_buyruk_i[11:7];
        yrt.yaz_yazmac <= (mikroislem != GECERSIZ);
        yrt.ps         <= gtr_ps_i;
        yrt.gecersiz   <= (mikroislem == GECERSIZ);
    end

endmodule

/* denetim_durum_birimi.sv */
// Forwarding only and no stall logic, since every result is ready after one execute cycle.
`timescale 1ns/1ps

module denetim_durum_birimi (
    input  logic [4:0]               cyo_rs1_adres_i,
    input  logic [4:0]               cyo_rs2_adres_i,
    cyo_yrt_if.hedef                 yrt,
    yrt_gy_if.hedef                  gy,
    output cekirdek_pkg::yonlendir_t cyo_yonlendir_kontrol1_o,
    output cekirdek_pkg::yonlendir_t cyo_yonlendir_kontrol2_o
);

    import cekirdek_pkg::*;

    // The youngest writer wins, so execute is tested first.
    function automatic yonlendir_t sec(input logic [4:0] rs);
        if (rs == 5'd0) begin
            return YAZMAC;
        end
        if (yrt.gecerli && yrt.yaz_yazmac && yrt.rd_adres == rs) begin
            return YRT;
        end
        if (gy.gecerli && gy.yaz_yazmac && gy.rd_adres == rs) begin
            return GY;
        end
        return YAZMAC;
    endfunction

    always_comb begin
        cyo_yonlendir_kontrol1_o = sec(cyo_rs1_adres_i);
        cyo_yonlendir_kontrol2_o = sec(cyo_rs2_adres_i);
    end

endmodule

/* geri_yaz.sv */
// The register write and the retire trace are the same registered signals.
`timescale 1ns/1ps

module geri_yaz (
    input  logic                          clk_i,
    input  logic                          rst_i,
    yrt_gy_if.hedef                       yrt,
    output logic [4:0]                    cyo_yaz_adres_o,
    output logic [cekirdek_pkg::XLEN-1:0] cyo_yaz_deger_o,
    output logic                          cyo_yaz_yazmac_o,
    output logic                          gecerli_o,
    output logic [cekirdek_pkg::XLEN-1:0] ps_o,
    output logic                          gecersiz_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gecerli_o        <= 1'b0;
            cyo_yaz_yazmac_o <= 1'b0;
            gecersiz_o       <= 1'b0;
        end else begin
            gecerli_o        <= yrt.gecerli;
            // x0 is never written.
            cyo_yaz_yazmac_o <= yrt.gecerli && yrt.yaz_yazmac && (yrt.rd_adres != 5'd0);
            gecersiz_o       <= yrt.gecerli && yrt.gecersiz;
        end
    end

    always_ff @(posedge clk_i) begin
        cyo_yaz_adres_o <= yrt.rd_adres;
        cyo_yaz_deger_o <= yrt.rd_deger;
        ps_o            <= yrt.ps;
    end

endmodule

/* getir.sv */
// The L1 must return each word in the cycle after acceptance and the PC only ever steps by 4.
`timescale 1ns/1ps

module getir (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          l1b_bekle_i,
    input  logic [cekirdek_pkg::XLEN-1:0] l1b_deger_i,
    output logic                          l1b_chip_select_n_o,
    output logic [cekirdek_pkg::XLEN-1:0] l1b_adres_o,
    output logic                          cyo_gecerli_o,
    output logic [cekirdek_pkg::XLEN-1:0] cyo_buyruk_o,
    output logic [cekirdek_pkg::XLEN-1:0] cyo_ps_o
);

    import cekirdek_pkg::*;

    logic            basla_r;
    logic            kabul_r;
    logic            kabul;
    logic [XLEN-1:0] ps_r;

    // A request completes only at an edge where bekle is low.
    assign kabul = basla_r & ~l1b_bekle_i;

    assign l1b_chip_select_n_o = ~basla_r;
    assign l1b_adres_o         = ps_r;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            basla_r       <= 1'b0;
            kabul_r       <= 1'b0;
            cyo_gecerli_o <= 1'b0;
            ps_r          <= '0;
        end else begin
            basla_r       <= 1'b1;
            kabul_r       <= kabul;
            cyo_gecerli_o <= kabul_r;
            if (kabul) begin
                ps_r <= ps_r + 32'd4;
            end
        end
    end

    // The word on the bus answers the request taken last cycle.
    // ps_r has already stepped past it, so its PC is ps_r - 4.
    always_ff @(posedge clk_i) begin
        cyo_buyruk_o <= l1b_deger_i;
        cyo_ps_o     <= ps_r - 32'd4;
    end

    // A stalled request keeps its address until the L1 takes it.
    a_adres_sabit: assert property (@(posedge clk_i) disable iff (rst_i)
        (!l1b_chip_select_n_o && l1b_bekle_i) |=> $stable(l1b_adres_o));

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_cekirdek -f src.f

out=$(./obj_dir/Vtb_cekirdek 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

/* src.f */
cekirdek_pkg.sv
boru_if.sv
getir.sv
coz_yazmacoku.sv
yurut.sv
geri_yaz.sv
denetim_durum_birimi.sv
cekirdek.sv
tb_denetleyici.sv
tb_cekirdek.sv

/* tb_cekirdek.sv */
// The memory answers one cycle after acceptance and the first 31 words load x1..x31 with addi.
`timescale 1ns/1ps

module tb_cekirdek;

    localparam int BELLEK_DERINLIK = 1024;
    localparam int EMEKLI_HEDEF    = 600;
    localparam int ZAMAN_ASIMI     = 20000;

    logic        clk = 1'b0;
    logic        rst;
    logic        l1b_bekle;
    logic [31:0] l1b_deger;
    logic        l1b_cs_n;
    logic [31:0] l1b_adres;
    logic        gy_gecerli;
    logic [31:0] gy_ps;
    logic        gy_yaz_yazmac;
    logic [4:0]  gy_rd_adres;
    logic [31:0] gy_rd_deger;
    logic        gy_gecersiz;
    logic        bitti;
    int          hata_sayisi;

    logic [31:0] program_bellegi [0:BELLEK_DERINLIK-1];
    logic [31:0] lfsr_r;
    logic [31:0] zar;
    logic        bekleyen_var;
    logic [31:0] bekleyen_kelime;

    always #2 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken.
    function automatic logic [31:0] rastgele(input int n);
        logic [31:0] r;
        logic        yeni_bit;
        r = 32'h0;
        for (int i = 0; i < n; i++) begin
            yeni_bit = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
            lfsr_r   = {lfsr_r[30:0], yeni_bit};
            r        = {r[30:0], yeni_bit};
        end
        return r;
    endfunction

    // One word in sixteen is garbage, the rest are OP, OP-IMM or LUI on x0..x7.
    function automatic logic [31:0] buyruk_uret();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r = rastgele(4);
        if (r[3:0] == 4'd0) begin
            return rastgele(32);
        end
        r   = rastgele(12);
        rd  = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3  = r[11:9];
        r   = rastgele(3);
        f7  = (r[0] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        case (r[2:1])
            2'd0, 2'd1: return {f7, rs2, rs1, f3, rd, 7'h33};
            2'd2: begin
                r = rastgele(12);
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    return {f7, r[4:0], rs1, f3, rd, 7'h13};
                end
                return {r[11:0], rs1, f3, rd, 7'h13};
            end
            default: begin
                r = rastgele(20);
                return {r[19:0], rd, 7'h37};
            end
        endcase
    endfunction

    // ============================================================
    // Program memory and L1 model.
    // ============================================================
    initial begin
        lfsr_r          = 32'd67481;
        l1b_bekle       = 1'b0;
        l1b_deger       = 32'h0;
        bekleyen_var    = 1'b0;
        bekleyen_kelime = 32'h0;
        for (int i = 0; i < BELLEK_DERINLIK; i++) begin
            if (i < 31) begin
                zar                = rastgele(12);
                program_bellegi[i] = {zar[11:0], 5'd0, 3'b000, 5'(i + 1), 7'h13};
            end else begin
                program_bellegi[i] = buyruk_uret();
            end
        end
        forever begin
            @(negedge clk);
            // The word accepted at the last edge is on the bus for this one.
            if (bekleyen_var) begin
                l1b_deger = bekleyen_kelime;
            end else begin
                l1b_deger = rastgele(32);
            end
            zar             = rastgele(2);
            l1b_bekle       = (zar[1:0] == 2'b00);
            bekleyen_var    = !l1b_cs_n && !l1b_bekle;
            bekleyen_kelime = program_bellegi[l1b_adres[11:2]];
        end
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < ZAMAN_ASIMI && !bitti; i++) begin
            @(negedge clk);
        end
        if (!bitti) begin
            $display("timeout: the core did not retire %0d instructions in %0d cycles",
                     EMEKLI_HEDEF, ZAMAN_ASIMI);
            $display("tests failed");
        end else if (hata_sayisi == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    cekirdek UUT (
        .clk_i               (clk          ),
        .rst_i               (rst          ),
        .l1b_bekle_i         (l1b_bekle    ),
        .l1b_deger_i         (l1b_deger    ),
        .l1b_chip_select_n_o (l1b_cs_n     ),
        .l1b_adres_o         (l1b_adres    ),
        .gy_gecerli_o        (gy_gecerli   ),
        .gy_ps_o             (gy_ps        ),
        .gy_yaz_yazmac_o     (gy_yaz_yazmac),
        .gy_rd_adres_o       (gy_rd_adres  ),
        .gy_rd_deger_o       (gy_rd_deger  ),
        .gy_gecersiz_o       (gy_gecersiz  )
    );

    tb_denetleyici #(
        .EMEKLI_HEDEF (EMEKLI_HEDEF)
    ) denetleyici (
        .clk_i      (clk          ),
        .rst_i      (rst          ),
        .bekle_i    (l1b_bekle    ),
        .deger_i    (l1b_deger    ),
        .cs_n_i     (l1b_cs_n     ),
        .adres_i    (l1b_adres    ),
        .gecerli_i  (gy_gecerli   ),
        .ps_i       (gy_ps        ),
        .yaz_i      (gy_yaz_yazmac),
        .rd_adres_i (gy_rd_adres  ),
        .rd_deger_i (gy_rd_deger  ),
        .gecersiz_i (gy_gecersiz  ),
        .bitti_o    (bitti        ),
        .hata_o     (hata_sayisi  )
    );

endmodule

/* tb_denetleyici.sv */
// Expects every returned word to retire in order exactly four cycles later, with x0 reading zero.
`timescale 1ns/1ps

module tb_denetleyici #(
    parameter int EMEKLI_HEDEF = 600
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        bekle_i,
    input  logic [31:0] deger_i,
    input  logic        cs_n_i,
    input  logic [31:0] adres_i,
    input  logic        gecerli_i,
    input  logic [31:0] ps_i,
    input  logic        yaz_i,
    input  logic [4:0]  rd_adres_i,
    input  logic [31:0] rd_deger_i,
    input  logic        gecersiz_i,
    output logic        bitti_o,
    output int          hata_o
);

    typedef struct packed {
        logic [31:0] dongu;
        logic [31:0] ps;
        logic [31:0] buyruk;
    } getirilen_t;

    localparam int T_RESET    = 0;
    localparam int T_SIRA     = 1;
    localparam int T_ALU      = 2;
    localparam int T_X0       = 3;
    localparam int T_GECERSIZ = 4;
    localparam int T_BEKLE    = 5;

    getirilen_t  kuyruk [$];
    logic [31:0] x_r [0:31];
    logic [31:0] beklenen_adres;
    logic [31:0] kabul_adres;
    logic [31:0] dongu;
    logic        kabul_onceki;
    logic        rst_onceki;
    logic        ilk_kabul;
    int          emekli;
    int          kontrol [0:5];
    int          hata [0:5];

    initial begin
        for (int i = 0; i < 32; i++) begin
            x_r[i] = 32'h0;
        end
        for (int t = 0; t < 6; t++) begin
            kontrol[t] = 0;
            hata[t]    = 0;
        end
        beklenen_adres = 32'h0;
        kabul_adres    = 32'h0;
        dongu          = 32'h0;
        kabul_onceki   = 1'b0;
        rst_onceki     = 1'b0;
        ilk_kabul      = 1'b1;
        emekli         = 0;
        bitti_o        = 1'b0;
        hata_o         = 0;
    end

    function automatic string adini_ver(input int t);
        case (t)
            T_RESET:    return "reset";
            T_SIRA:     return "fetch_order";
            T_ALU:      return "alu_results";
            T_X0:       return "x0";
            T_GECERSIZ: return "invalid";
            default:    return "stalls";
        endcase
    endfunction

    task automatic denetle(input int t, input logic kosul, input string mesaj);
        kontrol[t]++;
        if (kosul !== 1'b1) begin
            hata[t]++;
            $display("[ERROR] %0t: %s", $time, mesaj);
        end
    endtask

    task automatic bildir(input int t, input string mesaj);
        kontrol[t]++;
        hata[t]++;
        $display("%s", mesaj);
    endtask

    task automatic test_satiri(input int t);
        $display("test %s: %s, %0d checks, %0d errors", adini_ver(t),
                 (hata[t] == 0) ? "PASS" : "FAIL", kontrol[t], hata[t]);
    endtask

    // ============================================================
    // Reference model built from the RV32I encodings.
    // ============================================================
    task automatic modeli_calistir(input logic [31:0] w, output logic gecerli,
                                   output logic [31:0] sonuc);
        logic        op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sa;
        logic [2:0]  f3;
        logic [6:0]  f7;
        op = (w[6:0] == 7'h33);
        f3 = w[14:12];
        f7 = w[31:25];
        a  = x_r[w[19:15]];
        b  = op ? x_r[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sa = b[4:0];
        sonuc = 32'h0;
        if (w[6:0] == 7'h37) begin
            gecerli = 1'b1;
            sonuc   = {w[31:12], 12'h000};
        end else if (op || w[6:0] == 7'h13) begin
            if (op) begin
                gecerli = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end else if (f3 == 3'd1) begin
                gecerli = (f7 == 7'h00);
            end else if (f3 == 3'd5) begin
                gecerli = (f7 == 7'h00 || f7 == 7'h20);
            end else begin
                gecerli = 1'b1;
            end
            case (f3)
                3'd0:    sonuc = (op && w[30]) ? a - b : a + b;
                3'd1:    sonuc = a << sa;
                3'd2:    sonuc = {31'b0, $signed(a) < $signed(b)};
                3'd3:    sonuc = {31'b0, a < b};
                3'd4:    sonuc = a ^ b;
                3'd5:    sonuc = w[30] ? $unsigned($signed(a) >>> sa) : a >> sa;
                3'd6:    sonuc = a | b;
                default: sonuc = a & b;
            endcase
        end else begin
            gecerli = 1'b0;
        end
    endtask

    // ============================================================
    // Fetch side.
    // ============================================================
    task automatic getirmeyi_izle();
        getirilen_t yeni;
        if (kabul_onceki) begin
            yeni.dongu  = dongu;
            yeni.ps     = kabul_adres;
            yeni.buyruk = deger_i;
            kuyruk.push_back(yeni);
        end
        kabul_onceki = 1'b0;
        if (!cs_n_i) begin
            denetle(T_SIRA, adres_i == beklenen_adres,
                    $sformatf("fetch address %h, expected %h", adres_i, beklenen_adres));
            if (!bekle_i) begin
                if (ilk_kabul) begin
                    denetle(T_RESET, adres_i == 32'h0,
                            $sformatf("first accepted address %h, expected 0", adres_i));
                    test_satiri(T_RESET);
                    ilk_kabul = 1'b0;
                end
                kabul_adres    = adres_i;
                beklenen_adres = beklenen_adres + 32'd4;
                kabul_onceki   = 1'b1;
            end
        end
    endtask

    // ============================================================
    // Retire side.
    // ============================================================
    task automatic emekliyi_denetle();
        getirilen_t  g;
        logic        m_gecerli;
        logic [31:0] m_sonuc;
        logic [4:0]  rd;
        if (gecerli_i) begin
            if (kuyruk.size() == 0) begin
                bildir(T_BEKLE,
                       $sformatf("instruction at pc %h retired at %0t with no fetched word waiting",
                                 ps_i, $time));
            end else begin
                g  = kuyruk.pop_front();
                rd = g.buyruk[11:7];
                denetle(T_SIRA, ps_i == g.ps,
                        $sformatf("retired pc %h, expected %h", ps_i, g.ps));
                denetle(T_BEKLE, dongu == g.dongu + 32'd4,
                        $sformatf("pc %h retired %0d cycles after its word, expected 4",
                                  g.ps, dongu - g.dongu));
                modeli_calistir(g.buyruk, m_gecerli, m_sonuc);
                if (!m_gecerli) begin
                    denetle(T_GECERSIZ, gecersiz_i && !yaz_i,
                            $sformatf("pc %h word %h: gecersiz %b write %b, expected 1 and 0",
                                      g.ps, g.buyruk, gecersiz_i, yaz_i));
                end else if (rd == 5'd0) begin
                    denetle(T_X0, !yaz_i && !gecersiz_i,
                            $sformatf("pc %h writes x0: write %b gecersiz %b",
                                      g.ps, yaz_i, gecersiz_i));
                end else begin
                    denetle(T_ALU,
                            yaz_i && !gecersiz_i && rd_adres_i == rd && rd_deger_i == m_sonuc,
                            $sformatf("pc %h word %h: x%0d = %h write %b, expected x%0d = %h",
                                      g.ps, g.buyruk, rd_adres_i, rd_deger_i, yaz_i,
                                      rd, m_sonuc));
                    x_r[rd] = m_sonuc;
                end
                emekli++;
            end
        end
        if (kuyruk.size() > 0 && kuyruk[0].dongu + 32'd4 < dongu) begin
            g = kuyruk.pop_front();
            bildir(T_BEKLE, $sformatf("word at pc %h was returned but never retired", g.ps));
        end
    endtask

    task automatic raporla();
        int gecen;
        int toplam_kontrol;
        gecen          = 0;
        toplam_kontrol = 0;
        hata_o         = 0;
        for (int t = 1; t < 6; t++) begin
            test_satiri(t);
        end
        for (int t = 0; t < 6; t++) begin
            gecen          = gecen + ((hata[t] == 0) ? 1 : 0);
            toplam_kontrol = toplam_kontrol + kontrol[t];
            hata_o         = hata_o + hata[t];
        end
        $display("summary: passing %0d/6, checks %0d, errors %0d, retired %0d",
                 gecen, toplam_kontrol, hata_o, emekli);
    endtask

    always @(posedge clk_i) begin
        dongu = dongu + 32'd1;
        if (rst_onceki) begin
            denetle(T_RESET, cs_n_i && !gecerli_i,
                    $sformatf("reset state: cs_n %b gecerli %b, expected 1 and 0",
                              cs_n_i, gecerli_i));
        end
        rst_onceki = rst_i;
        if (!rst_i && !bitti_o) begin
            getirmeyi_izle();
            emekliyi_denetle();
            if (emekli == EMEKLI_HEDEF) begin
                raporla();
                bitti_o = 1'b1;
            end
        end
    end

endmodule

/* yurut.sv */
// Single-cycle ALU; shifts use the low five bits of the second operand only.
`timescale 1ns/1ps

module yurut (
    input  logic                          clk_i,
    input  logic                          rst_i,
    cyo_yrt_if.hedef                      cyo,
    yrt_gy_if.kaynak                      gy,
    output logic [cekirdek_pkg::XLEN-1:0] cyo_yonlendir_deger_o
);

    import cekirdek_pkg::*;

    logic [XLEN-1:0] sonuc;
    logic [4:0]      kaydir;

    assign kaydir = cyo.deger2[4:0];

    always_comb begin
        case (cyo.mikroislem)
            TOPLA:   sonuc = cyo.deger1 + cyo.deger2;
            CIKAR:   sonuc = cyo.deger1 - cyo.deger2;
            VE:      sonuc = cyo.deger1 & cyo.deger2;
            VEYA:    sonuc = cyo.deger1 | cyo.deger2;
            XOR:     sonuc = cyo.deger1 ^ cyo.deger2;
            SLT:     sonuc = {31'b0, $signed(cyo.deger1) < $signed(cyo.deger2)};
            SLTU:    sonuc = {31'b0, cyo.deger1 < cyo.deger2};
            SLL:     sonuc = cyo.deger1 << kaydir;
            SRL:     sonuc = cyo.deger1 >> kaydir;
            SRA:     sonuc = $unsigned($signed(cyo.deger1) >>> kaydir);
            LUI_OP:  sonuc = cyo.deger2;
            default: sonuc = '0;
        endcase
    end

    // Decode sees this value in the same cycle.
    assign cyo_yonlendir_deger_o = sonuc;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gy.gecerli <= 1'b0;
        end else begin
            gy.gecerli <= cyo.gecerli;
        end
    end

    always_ff @(posedge clk_i) begin
        gy.rd_adres   <= cyo.rd_adres;
        gy.rd_deger   <= sonuc;
        gy.yaz_yazmac <= cyo.yaz_yazmac;
        gy.ps         <= cyo.ps;
        gy.gecersiz   <= cyo.gecersiz;
    end

    // An invalid word from decode never asks for a register write.
    a_gecersiz_yazmaz: assert property (@(posedge clk_i) disable iff (rst_i)
        (cyo.gecerli && cyo.gecersiz) |-> !cyo.yaz_yazmac);

endmodule
